/* common/id_pkg.sv */
// decode stage shared definitions
package id_pkg;

  localparam int XLEN      = 64;
  localparam int INST_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_GPR   = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JUMP
  } br_kind_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                 wen;
    logic [REG_IDX_W-1:0] waddr;
    logic [XLEN-1:0]      wdata;
  } wb_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] es_rd;
    logic [REG_IDX_W-1:0] ms_rd;
    logic [REG_IDX_W-1:0] ws_rd;
  } later_rd_t;

  typedef struct packed {
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      word_cut;   // 32-bit forms, result sign-extended from bit 31
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    logic [2:0] mem_op;    // funct3 of load/store
    logic      uses_rs1;
    logic      uses_rs2;
    br_kind_e  br_kind;
    logic      is_jalr;
    logic      invalid;
  } dec_ctrl_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;
    logic [REG_IDX_W-1:0] rd;
    dec_ctrl_t            ctrl;
  } ds_to_es_t;

endpackage

/* hw/id_gpr_file.sv */
// general purpose register file
`timescale 1ns/1ps

module id_gpr_file (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic [id_pkg::REG_IDX_W-1:0] i_raddr1,
  input  logic [id_pkg::REG_IDX_W-1:0] i_raddr2,
  output logic [id_pkg::XLEN-1:0]      o_rdata1,
  output logic [id_pkg::XLEN-1:0]      o_rdata2,
  input  id_pkg::wb_t                  i_wb
);

  logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_GPR];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < id_pkg::NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0) begin  // x0 never written
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no bypass, a write shows up the cycle after
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // write-back must present a resolved index with its enable
  a_wb_addr_known: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_wb.wen |-> !$isunknown(i_wb.waddr)
  );

endmodule

/* decoder/id_decoder.sv */
// rv64i instruction decoder
`timescale 1ns/1ps

module id_decoder (
  input  logic [id_pkg::INST_W-1:0]    i_inst,
  output logic [id_pkg::REG_IDX_W-1:0] o_rs1,
  output logic [id_pkg::REG_IDX_W-1:0] o_rs2,
  output logic [id_pkg::REG_IDX_W-1:0] o_rd,
  output logic [id_pkg::XLEN-1:0]      o_imm,
  output id_pkg::dec_ctrl_t            o_ctrl
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                    bad;

  function automatic id_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    id_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  op = id_pkg::ALU_SLL;
      3'b010:  op = id_pkg::ALU_SLT;
      3'b011:  op = id_pkg::ALU_SLTU;
      3'b100:  op = id_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  op = id_pkg::ALU_OR;
      default: op = id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: o_imm = imm_u;
      id_pkg::OPC_JAL:                    o_imm = imm_j;
      id_pkg::OPC_BRANCH:                 o_imm = imm_b;
      id_pkg::OPC_STORE:                  o_imm = imm_s;
      default:                            o_imm = imm_i;
    endcase
  end

  always_comb begin
    o_ctrl = '0;  // add, rs1/rs2 sources, no branch
    bad    = 1'b0;
    case (opcode)
      id_pkg::OPC_LUI: begin
        o_ctrl.alu_op   = id_pkg::ALU_COPY_B;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        o_ctrl.src1_sel = id_pkg::SRC1_PC;
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        o_ctrl.src1_sel = id_pkg::SRC1_PC;  // link value pc + 4
        o_ctrl.src2_sel = id_pkg::SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.br_kind  = id_pkg::BR_JUMP;
        o_ctrl.is_jalr  = (opcode == id_pkg::OPC_JALR);
        o_ctrl.uses_rs1 = (opcode == id_pkg::OPC_JALR);
        bad             = (opcode == id_pkg::OPC_JALR) && (funct3 != 3'b000);
      end
      id_pkg::OPC_BRANCH: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  o_ctrl.br_kind = id_pkg::BR_BEQ;
          3'b001:  o_ctrl.br_kind = id_pkg::BR_BNE;
          3'b100:  o_ctrl.br_kind = id_pkg::BR_BLT;
          3'b101:  o_ctrl.br_kind = id_pkg::BR_BGE;
          3'b110:  o_ctrl.br_kind = id_pkg::BR_BLTU;
          3'b111:  o_ctrl.br_kind = id_pkg::BR_BGEU;
          default: bad = 1'b1;
        endcase
      end
      id_pkg::OPC_LOAD, id_pkg::OPC_STORE: begin
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;  // address = rs1 + imm
        o_ctrl.mem_op   = funct3;
        o_ctrl.uses_rs1 = 1'b1;
        if (opcode == id_pkg::OPC_LOAD) begin
          o_ctrl.mem_ren = 1'b1;
          o_ctrl.gpr_wen = 1'b1;
          bad            = (funct3 == 3'b111);
        end else begin
          o_ctrl.mem_wen  = 1'b1;
          o_ctrl.uses_rs2 = 1'b1;
          bad             = funct3[2];
        end
      end
      id_pkg::OPC_OP_IMM, id_pkg::OPC_OP_IMM_32: begin
        o_ctrl.alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_ctrl.src2_sel = id_pkg::SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        if (opcode == id_pkg::OPC_OP_IMM) begin
          // 6-bit shamt, funct6 checked
          bad = (funct3 == 3'b001 && i_inst[31:26] != 6'b0) ||
                (funct3 == 3'b101 && (i_inst[31] || i_inst[29:26] != 4'b0));
        end else begin
          o_ctrl.word_cut = 1'b1;
          bad = !(funct3 == 3'b000 || (funct3 == 3'b001 && funct7 == 7'b0) ||
                  (funct3 == 3'b101 && (funct7 & 7'b1011111) == 7'b0));
        end
      end
      id_pkg::OPC_OP, id_pkg::OPC_OP_32: begin
        o_ctrl.alu_op   = alu_from_funct3(funct3, funct7[5]);
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        o_ctrl.word_cut = (opcode == id_pkg::OPC_OP_32);
        // alt encoding only for sub and sra
        bad = !(funct7 == 7'b0 ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
        if (opcode == id_pkg::OPC_OP_32 && !(funct3 inside {3'b000, 3'b001, 3'b101}))
          bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      o_ctrl         = '0;  // no writes, no sources, no branch
      o_ctrl.invalid = 1'b1;
    end
  end

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = o_ctrl.gpr_wen ? i_inst[11:7] : '0;  // 0 means nothing pending downstream

endmodule

/* hw/id_hazard_check.sv */
// source register hazard detect
`timescale 1ns/1ps

module id_hazard_check (
  input  logic [id_pkg::REG_IDX_W-1:0] i_rs1,
  input  logic [id_pkg::REG_IDX_W-1:0] i_rs2,
  input  logic                         i_uses_rs1,
  input  logic                         i_uses_rs2,
  input  id_pkg::later_rd_t            i_later_rd,
  output logic                         o_stall
);

  logic es_hit;
  logic ms_hit;
  logic ws_hit;

  function automatic logic owes_src(input logic [id_pkg::REG_IDX_W-1:0] rd);
    logic hit1;
    logic hit2;
    hit1 = i_uses_rs1 && (rd == i_rs1);
    hit2 = i_uses_rs2 && (rd == i_rs2);
    return (rd != '0) && (hit1 || hit2);  // x0 is never pending
  endfunction

  assign es_hit = owes_src(i_later_rd.es_rd);
  assign ms_hit = owes_src(i_later_rd.ms_rd);
  assign ws_hit = owes_src(i_later_rd.ws_rd);  // no forwarding, wait through write-back

  assign o_stall = es_hit || ms_hit || ws_hit;

endmodule

/* hw/id_branch_unit.sv */
// branch resolve and target
`timescale 1ns/1ps

module id_branch_unit (
  input  id_pkg::br_kind_e        i_br_kind,
  input  logic                    i_is_jalr,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  input  logic [id_pkg::XLEN-1:0] i_rs1_data,
  input  logic [id_pkg::XLEN-1:0] i_rs2_data,
  output logic                    o_br_hit,
  output logic [id_pkg::XLEN-1:0] o_target
);

  logic                    eq;
  logic                    lt_s;
  logic                    lt_u;
  logic [id_pkg::XLEN-1:0] pc_rel;
  logic [id_pkg::XLEN-1:0] reg_rel;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_kind)
      id_pkg::BR_BEQ:  o_br_hit = eq;
      id_pkg::BR_BNE:  o_br_hit = !eq;
      id_pkg::BR_BLT:  o_br_hit = lt_s;
      id_pkg::BR_BGE:  o_br_hit = !lt_s;
      id_pkg::BR_BLTU: o_br_hit = lt_u;
      id_pkg::BR_BGEU: o_br_hit = !lt_u;
      id_pkg::BR_JUMP: o_br_hit = 1'b1;  // jal and jalr
      default:         o_br_hit = 1'b0;
    endcase
  end

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;

  // jalr drops bit 0 of the sum
  assign o_target = i_is_jalr ? {reg_rel[id_pkg::XLEN-1:1], 1'b0} : pc_rel;

endmodule

/* hw/id_stage_ctrl.sv */
// decode stage register and handshake
`timescale 1ns/1ps

module id_stage_ctrl (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_fs_valid,
  input  id_pkg::fs_to_ds_t            i_fs_bus,
  output logic                         o_ds_allowin,
  input  logic                         i_es_allowin,
  input  logic                         i_stall,
  input  logic                         i_br_hit,
  input  logic [id_pkg::XLEN-1:0]      i_target,
  input  logic [id_pkg::XLEN-1:0]      i_rs1_data,
  input  logic [id_pkg::XLEN-1:0]      i_rs2_data,
  input  logic [id_pkg::XLEN-1:0]      i_imm,
  input  logic [id_pkg::REG_IDX_W-1:0] i_rd,
  input  id_pkg::dec_ctrl_t            i_ctrl,
  output logic [id_pkg::INST_W-1:0]    o_inst,
  output logic [id_pkg::XLEN-1:0]      o_pc,
  output logic                         o_ds_to_es_valid,
  output id_pkg::ds_to_es_t            o_ds_to_es_bus,
  output id_pkg::br_bus_t              o_br_bus
);

  logic              ds_valid;
  logic              ds_ready_go;
  id_pkg::fs_to_ds_t ds_bus_r;

  assign ds_ready_go      = !i_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) ds_valid <= 1'b0;
    else if (o_ds_allowin) ds_valid <= i_fs_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) ds_bus_r <= i_fs_bus;
  end

  assign o_inst = ds_bus_r.inst;
  assign o_pc   = ds_bus_r.pc;

  // unused sources go out as zero so stray write-backs cannot disturb a held bundle
  assign o_ds_to_es_bus.rs1_data = i_ctrl.uses_rs1 ? i_rs1_data : '0;
  assign o_ds_to_es_bus.rs2_data = i_ctrl.uses_rs2 ? i_rs2_data : '0;
  assign o_ds_to_es_bus.imm      = i_imm;
  assign o_ds_to_es_bus.pc       = ds_bus_r.pc;
  assign o_ds_to_es_bus.rd       = i_rd;
  assign o_ds_to_es_bus.ctrl     = i_ctrl;

  assign o_br_bus.taken  = ds_valid && ds_ready_go && i_br_hit;  // level until accepted
  assign o_br_bus.target = i_target;

  a_bundle_hold: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_ds_to_es_valid && !i_es_allowin |=> $stable(o_ds_to_es_bus)
  );

  // redirect only for a decoded branch or jump
  a_taken_kind: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_br_bus.taken |-> (o_ds_to_es_bus.ctrl.br_kind != id_pkg::BR_NONE)
  );

endmodule

/* hw/id_stage_top.sv */
// instruction decode stage
`timescale 1ns/1ps

module id_stage_top (
  input  logic              i_clk,
  input  logic              i_arst_n,
  // fetch side
  input  logic              i_fs_valid,
  input  id_pkg::fs_to_ds_t i_fs_bus,
  output logic              o_ds_allowin,
  // write-back and pending destinations
  input  id_pkg::wb_t       i_wb,
  input  id_pkg::later_rd_t i_later_rd,
  // execute side
  input  logic              i_es_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es_bus,
  // back to fetch
  output id_pkg::br_bus_t   o_br_bus
);

  logic [id_pkg::INST_W-1:0]    ds_inst;
  logic [id_pkg::XLEN-1:0]      ds_pc;
  logic [id_pkg::REG_IDX_W-1:0] rs1;
  logic [id_pkg::REG_IDX_W-1:0] rs2;
  logic [id_pkg::REG_IDX_W-1:0] rd;
  logic [id_pkg::XLEN-1:0]      imm;
  id_pkg::dec_ctrl_t            ctrl;
  logic [id_pkg::XLEN-1:0]      rs1_data;
  logic [id_pkg::XLEN-1:0]      rs2_data;
  logic                         stall;
  logic                         br_hit;
  logic [id_pkg::XLEN-1:0]      br_target;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_bus         (i_fs_bus),
    .o_ds_allowin     (o_ds_allowin),
    .i_es_allowin     (i_es_allowin),
    .i_stall          (stall),
    .i_br_hit         (br_hit),
    .i_target         (br_target),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_imm            (imm),
    .i_rd             (rd),
    .i_ctrl           (ctrl),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus),
    .o_br_bus         (o_br_bus)
  );

  id_decoder u_decoder (
    .i_inst (ds_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wb     (i_wb)
  );

  id_hazard_check u_hazard (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_uses_rs1 (ctrl.uses_rs1),
    .i_uses_rs2 (ctrl.uses_rs2),
    .i_later_rd (i_later_rd),
    .o_stall    (stall)
  );

  id_branch_unit u_bru (
    .i_br_kind  (ctrl.br_kind),
    .i_is_jalr  (ctrl.is_jalr),
    .i_pc       (ds_pc),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_br_hit   (br_hit),
    .o_target   (br_target)
  );

endmodule

/* test/id_tb_clock.sv */
// testbench clock and reset
`timescale 1ns/1ps

module id_tb_clock (
  output logic o_clk,
  output logic o_arst_n
);

  localparam real HALF_NS    = 50.0;  // 100 ns period
  localparam int  RST_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);  // release away from the active edge
    o_arst_n = 1'b1;
  end

endmodule

/* test/id_stage_tb.sv */
// decode stage testbench
`timescale 1ns/1ps

module id_stage_tb;

  localparam int WAIT_LIMIT = 50;  // cycles per wait loop

  logic                 clk;
  logic                 arst_n;
  logic                 fs_valid;
  id_pkg::fs_to_ds_t    fs_bus;
  logic                 ds_allowin;
  id_pkg::wb_t          wb;
  id_pkg::later_rd_t    later_rd;
  logic                 es_allowin;
  logic                 ds_to_es_valid;
  id_pkg::ds_to_es_t    ds_to_es_bus;
  id_pkg::br_bus_t      br_bus;

  logic [id_pkg::XLEN-1:0] shadow [id_pkg::NUM_GPR];  // mirror of the register file
  id_pkg::fs_to_ds_t       in_flight [$];
  logic [31:0]             seed = 32'h2f06_be97;
  int                      sent;
  int                      out_count;
  int                      n_checks;
  int                      value_errs;
  int                      other_errs;

  id_tb_clock u_clk (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  id_stage_top i_dut (
    .i_clk            (clk),
    .i_arst_n         (arst_n),
    .i_fs_valid       (fs_valid),
    .i_fs_bus         (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .i_wb             (wb),
    .i_later_rd       (later_rd),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_to_es_bus),
    .o_br_bus         (br_bus)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] opc, input logic [6:0] f7,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, id_pkg::OPC_JAL};
  endfunction

  // legal encodings of the non-branch classes
  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [2:0]  f3w;
    logic [6:0]  f7;
    r   = next_rand();
    s   = next_rand();
    f3  = r[14:12];
    f3w = (s[5:4] == 2'd0) ? 3'b000 : (s[5:4] == 2'd1) ? 3'b001 : 3'b101;
    case (s[2:0])
      3'd0: return {s[31:12], r[11:7], id_pkg::OPC_LUI};
      3'd1: return {s[31:12], r[11:7], id_pkg::OPC_AUIPC};
      3'd2: begin
        if (f3 == 3'b001) return {6'b0, r[25:7], id_pkg::OPC_OP_IMM};
        if (f3 == 3'b101) return {1'b0, s[3], 4'b0, r[25:7], id_pkg::OPC_OP_IMM};
        return {r[31:7], id_pkg::OPC_OP_IMM};
      end
      3'd3: begin
        f7 = (s[3] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        return {f7, r[24:7], id_pkg::OPC_OP};
      end
      3'd4: begin
        f7 = (s[3] && f3w != 3'b001) ? 7'b0100000 : 7'b0;
        return {f7, r[24:15], f3w, r[11:7], id_pkg::OPC_OP_32};
      end
      3'd5: begin
        if (f3w == 3'b000) return {r[31:15], f3w, r[11:7], id_pkg::OPC_OP_IMM_32};
        f7 = (s[3] && f3w == 3'b101) ? 7'b0100000 : 7'b0;
        return {f7, r[24:15], f3w, r[11:7], id_pkg::OPC_OP_IMM_32};
      end
      3'd6: begin
        f3 = (f3 == 3'b111) ? 3'b110 : f3;
        return {r[31:15], f3, r[11:7], id_pkg::OPC_LOAD};
      end
      default: return {r[31:15], 1'b0, f3[1:0], r[11:7], id_pkg::OPC_STORE};
    endcase
  endfunction

  function automatic id_pkg::alu_op_e alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  return id_pkg::ALU_SLL;
      3'b010:  return id_pkg::ALU_SLT;
      3'b011:  return id_pkg::ALU_SLTU;
      3'b100:  return id_pkg::ALU_XOR;
      3'b101:  return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  return id_pkg::ALU_OR;
      default: return id_pkg::ALU_AND;
    endcase
  endfunction

  function automatic id_pkg::ds_to_es_t expected_ds_to_es(input id_pkg::fs_to_ds_t f);
    id_pkg::ds_to_es_t e;
    id_pkg::dec_ctrl_t c;
    logic [31:0]       w;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              ok;
    w    = f.inst;
    f3   = w[14:12];
    f7   = w[31:25];
    e    = '0;
    c    = '0;
    ok   = 1'b1;
    e.pc = f.pc;
    case (w[6:0])
      id_pkg::OPC_LUI, id_pkg::OPC_AUIPC: e.imm = {{32{w[31]}}, w[31:12], 12'h000};
      id_pkg::OPC_JAL:    e.imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      id_pkg::OPC_BRANCH: e.imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      id_pkg::OPC_STORE:  e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
      default:            e.imm = {{52{w[31]}}, w[31:20]};
    endcase
    case (w[6:0])
      id_pkg::OPC_LUI: begin
        c.alu_op   = id_pkg::ALU_COPY_B;
        c.src2_sel = id_pkg::SRC2_IMM;
        c.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        c.src1_sel = id_pkg::SRC1_PC;
        c.src2_sel = id_pkg::SRC2_IMM;
        c.gpr_wen  = 1'b1;
      end
      id_pkg::OPC_JAL, id_pkg::OPC_JALR: begin
        c.src1_sel = id_pkg::SRC1_PC;  // link is pc + 4
        c.src2_sel = id_pkg::SRC2_FOUR;
        c.gpr_wen  = 1'b1;
        c.br_kind  = id_pkg::BR_JUMP;
        if (w[6:0] == id_pkg::OPC_JALR) begin
          c.is_jalr  = 1'b1;
          c.uses_rs1 = 1'b1;
          ok         = (f3 == 3'b000);
        end
      end
      id_pkg::OPC_BRANCH: begin
        c.uses_rs1 = 1'b1;
        c.uses_rs2 = 1'b1;
        case (f3)
          3'b000:  c.br_kind = id_pkg::BR_BEQ;
          3'b001:  c.br_kind = id_pkg::BR_BNE;
          3'b100:  c.br_kind = id_pkg::BR_BLT;
          3'b101:  c.br_kind = id_pkg::BR_BGE;
          3'b110:  c.br_kind = id_pkg::BR_BLTU;
          3'b111:  c.br_kind = id_pkg::BR_BGEU;
          default: ok = 1'b0;
        endcase
      end
      id_pkg::OPC_LOAD: begin
        c.src2_sel = id_pkg::SRC2_IMM;
        c.mem_op   = f3;
        c.uses_rs1 = 1'b1;
        c.mem_ren  = 1'b1;
        c.gpr_wen  = 1'b1;
        ok         = (f3 != 3'b111);
      end
      id_pkg::OPC_STORE: begin
        c.src2_sel = id_pkg::SRC2_IMM;
        c.mem_op   = f3;
        c.uses_rs1 = 1'b1;
        c.uses_rs2 = 1'b1;
        c.mem_wen  = 1'b1;
        ok         = (f3 < 3'b100);
      end
      id_pkg::OPC_OP_IMM, id_pkg::OPC_OP_IMM_32: begin
        c.alu_op   = alu_for(f3, f3 == 3'b101 && w[30]);
        c.src2_sel = id_pkg::SRC2_IMM;
        c.gpr_wen  = 1'b1;
        c.uses_rs1 = 1'b1;
        if (w[6:0] == id_pkg::OPC_OP_IMM) begin
          if (f3 == 3'b001) ok = (w[31:26] == 6'b0);
          if (f3 == 3'b101) ok = (w[31:26] == 6'b0) || (w[31:26] == 6'b010000);
        end else begin
          c.word_cut = 1'b1;
          ok = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'b0) ||
               (f3 == 3'b101 && (f7 == 7'b0 || f7 == 7'b0100000));
        end
      end
      id_pkg::OPC_OP, id_pkg::OPC_OP_32: begin
        c.alu_op   = alu_for(f3, f7[5]);
        c.gpr_wen  = 1'b1;
        c.uses_rs1 = 1'b1;
        c.uses_rs2 = 1'b1;
        ok = (f7 == 7'b0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
        if (w[6:0] == id_pkg::OPC_OP_32) begin
          c.word_cut = 1'b1;
          ok = ok && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101);
        end
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      c         = '0;
      c.invalid = 1'b1;
    end
    e.ctrl     = c;
    e.rd       = c.gpr_wen ? w[11:7] : 5'd0;
    e.rs1_data = c.uses_rs1 ? shadow[w[19:15]] : '0;
    e.rs2_data = c.uses_rs2 ? shadow[w[24:20]] : '0;
    return e;
  endfunction

  function automatic id_pkg::br_bus_t expected_br(input id_pkg::fs_to_ds_t f);
    id_pkg::ds_to_es_t       d;
    id_pkg::br_bus_t         b;
    logic [id_pkg::XLEN-1:0] a;
    logic [id_pkg::XLEN-1:0] c;
    d = expected_ds_to_es(f);
    a = d.rs1_data;
    c = d.rs2_data;
    case (d.ctrl.br_kind)
      id_pkg::BR_BEQ:  b.taken = (a == c);
      id_pkg::BR_BNE:  b.taken = (a != c);
      id_pkg::BR_BLT:  b.taken = ($signed(a) < $signed(c));
      id_pkg::BR_BGE:  b.taken = ($signed(a) >= $signed(c));
      id_pkg::BR_BLTU: b.taken = (a < c);
      id_pkg::BR_BGEU: b.taken = (a >= c);
      id_pkg::BR_JUMP: b.taken = 1'b1;
      default:         b.taken = 1'b0;
    endcase
    if (d.ctrl.is_jalr) b.target = (a + d.imm) & ~64'd1;
    else b.target = f.pc + d.imm;
    return b;
  endfunction

  task automatic check_ds_to_es(input id_pkg::ds_to_es_t got, input id_pkg::ds_to_es_t exp);
    n_checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL o_ds_to_es_bus got %h exp %h", got, exp);
    end
  endtask

  task automatic check_br(input id_pkg::br_bus_t got, input id_pkg::br_bus_t exp,
                          input logic with_target);
    n_checks++;
    if (got.taken !== exp.taken || (with_target && got.target !== exp.target)) begin
      value_errs++;
      $display("FAIL o_br_bus got %h exp %h", got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    other_errs++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  // offer one instruction and return on the falling edge after the transfer
  task automatic send_inst(input logic [31:0] inst, input logic [63:0] pc);
    int t;
    t           = 0;
    fs_valid    = 1'b1;
    fs_bus.inst = inst;
    fs_bus.pc   = pc;
    @(posedge clk);
    while (!ds_allowin) begin
      t++;
      if (t > WAIT_LIMIT) timed_out("the fetch handshake");
      @(posedge clk);
    end
    @(negedge clk);
    fs_valid = 1'b0;
    sent++;
  endtask

  task automatic wait_out(input int n);
    int t;
    t = 0;
    while (out_count < n) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) timed_out("instructions to leave decode");
    end
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [63:0] data);
    wb.wen   = 1'b1;
    wb.waddr = idx;
    wb.wdata = data;
    @(negedge clk);
    wb.wen = 1'b0;
  endtask

  task automatic expect_prompt(input logic [31:0] inst, input logic [63:0] pc);
    send_inst(inst, pc);
    @(negedge clk);
    if (out_count != sent) begin
      other_errs++;
      $display("instruction at pc %h stalled although no used source was owed", pc);
    end
  endtask

  always @(posedge clk) begin : compare_out
    id_pkg::fs_to_ds_t cur;
    id_pkg::ds_to_es_t exp_bus;
    if (arst_n) begin
      if (ds_to_es_valid && es_allowin) begin
        if (in_flight.size() == 0) begin
          other_errs++;
          $display("decode sent an instruction that was never accepted");
        end else begin
          cur     = in_flight.pop_front();
          exp_bus = expected_ds_to_es(cur);
          check_ds_to_es(ds_to_es_bus, exp_bus);
          check_br(br_bus, expected_br(cur), exp_bus.ctrl.br_kind != id_pkg::BR_NONE);
          out_count++;
        end
      end
      if (fs_valid && ds_allowin) in_flight.push_back(fs_bus);
      if (wb.wen && wb.waddr != 5'd0) shadow[wb.waddr] = wb.wdata;  // x0 stays zero
    end
  end

  initial begin : stimulus
    int                t;
    logic [31:0]       r;
    logic [12:0]       boff;
    logic [4:0]        ra;
    logic [4:0]        rb;
    logic [63:0]       pc;
    id_pkg::fs_to_ds_t held;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    wb         = '0;
    later_rd   = '0;
    es_allowin = 1'b1;
    pc         = 64'h0000_0000_8000_0000;
    for (int i = 0; i < id_pkg::NUM_GPR; i++) shadow[i] = '0;
    @(negedge clk);
    t = 0;
    while (!arst_n) begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) timed_out("reset release");
    end
    check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_bit("o_br_bus.taken", br_bus.taken, 1'b0);
    check_bit("o_ds_allowin", ds_allowin, 1'b1);
    @(negedge clk);

    // fill the register file then run random traffic with write-backs alongside
    for (int i = 1; i < id_pkg::NUM_GPR; i++) write_reg(i[4:0], {next_rand(), next_rand()});
    write_reg(5'd0, 64'hffff_0000_ffff_0000);
    send_inst(enc_r(id_pkg::OPC_OP, 7'b0, 3'b000, 5'd5, 5'd0, 5'd0), pc);
    for (int n = 0; n < 300; n++) begin
      r        = next_rand();
      wb.wen   = r[0];
      wb.waddr = r[5:1];
      wb.wdata = {next_rand(), next_rand()};
      pc       = pc + 64'd4;
      send_inst(random_inst(), pc);
    end
    wb.wen = 1'b0;
    wait_out(sent);

    write_reg(5'd1, 64'd5);
    write_reg(5'd2, 64'd5);
    write_reg(5'd3, 64'hffff_ffff_ffff_fffd);
    write_reg(5'd4, 64'h8000_0000_0000_0000);

    // each later stage owing a source holds the instruction
    for (int k = 0; k < 3; k++) begin
      later_rd = '0;
      case (k)
        0:       later_rd.es_rd = 5'd1;
        1:       later_rd.ms_rd = 5'd2;
        default: later_rd.ws_rd = 5'd1;
      endcase
      pc = pc + 64'd4;
      send_inst(enc_b(3'b000, 5'd1, 5'd2, 13'd64), pc);
      repeat (4) begin
        @(posedge clk);
        check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_bit("o_br_bus.taken", br_bus.taken, 1'b0);
        check_bit("o_ds_allowin", ds_allowin, 1'b0);
        @(negedge clk);
      end
      later_rd = '0;
      wait_out(sent);
    end
    // unused rs1 field of lui and unused rs2 field of addi
    later_rd.es_rd = 5'd7;
    expect_prompt({20'h00038, 5'd6, id_pkg::OPC_LUI}, pc + 64'd4);
    later_rd       = '0;
    later_rd.ws_rd = 5'd9;
    expect_prompt(enc_i(id_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd1, 12'h009), pc + 64'd8);
    later_rd = '0;
    expect_prompt(enc_i(id_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'h001), pc + 64'd12);
    pc = pc + 64'd12;

    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        for (int p = 0; p < 3; p++) begin
          ra   = (p == 1) ? 5'd3 : 5'd1;
          rb   = (p == 0) ? 5'd2 : (p == 1) ? 5'd1 : 5'd3;
          r    = next_rand();
          boff = {r[12:1], 1'b0};
          pc   = pc + 64'd4;
          send_inst(enc_b(f[2:0], ra, rb, boff), pc);
        end
        send_inst(enc_b(f[2:0], 5'd4, 5'd3, 13'h1ff0), pc + 64'd4);
        pc = pc + 64'd4;
      end
    end
    send_inst(enc_j(5'd1, 21'h1ffff4), pc + 64'd4);
    send_inst(enc_j(5'd0, 21'h000800), pc + 64'd8);
    send_inst(enc_i(id_pkg::OPC_JALR, 3'b000, 5'd1, 5'd3, 12'h7ff), pc + 64'd12);
    send_inst(enc_i(id_pkg::OPC_JALR, 3'b000, 5'd0, 5'd1, 12'h800), pc + 64'd16);
    pc = pc + 64'd16;
    wait_out(sent);

    // back-pressure from execute
    es_allowin = 1'b0;
    held.inst  = enc_r(id_pkg::OPC_OP, 7'b0100000, 3'b000, 5'd7, 5'd1, 5'd3);
    held.pc    = pc + 64'd4;
    pc         = pc + 64'd4;
    send_inst(held.inst, held.pc);
    repeat (4) begin
      @(posedge clk);
      check_bit("o_ds_allowin", ds_allowin, 1'b0);
      check_bit("o_ds_to_es_valid", ds_to_es_valid, 1'b1);
      check_ds_to_es(ds_to_es_bus, expected_ds_to_es(held));
      @(negedge clk);
    end
    es_allowin = 1'b1;
    @(negedge clk);
    repeat (2) @(negedge clk);
    if (out_count != sent) begin
      other_errs++;
      $display("expected one delivery after back-pressure, saw %0d", out_count - sent + 1);
    end

    // unknown opcodes and illegal funct fields
    send_inst({25'h0abcdef, 7'b1110011}, pc + 64'd4);
    send_inst({25'h1234567, 7'b0001111}, pc + 64'd8);
    send_inst(32'hffff_ffff, pc + 64'd12);
    send_inst(32'h0000_0000, pc + 64'd16);
    send_inst(enc_r(id_pkg::OPC_OP, 7'b0000001, 3'b000, 5'd8, 5'd1, 5'd2), pc + 64'd20);
    send_inst(enc_i(id_pkg::OPC_LOAD, 3'b111, 5'd8, 5'd1, 12'h010), pc + 64'd24);
    send_inst(enc_i(id_pkg::OPC_JALR, 3'b001, 5'd8, 5'd1, 12'h010), pc + 64'd28);
    send_inst(enc_b(3'b010, 5'd1, 5'd2, 13'd8), pc + 64'd32);
    wait_out(sent);

    finish_run();
  end

endmodule

/* id_stage.f */
common/id_pkg.sv
hw/id_gpr_file.sv
decoder/id_decoder.sv
hw/id_hazard_check.sv
hw/id_branch_unit.sv
hw/id_stage_ctrl.sv
hw/id_stage_top.sv
test/id_tb_clock.sv
test/id_stage_tb.sv
